// File: filelist.f
+incdir+hdl
hdl/rp_analog_pkg.sv
hdl/lock_reset_gen.sv
hdl/adc_input_stage.sv
hdl/dac_sum_sat.sv
hdl/dac_output_stage.sv
hdl/exp_io_mux.sv
hdl/rp_analog_top.sv
verif/tb_rp_analog.sv

// File: Makefile
# Verilator build and run of the analog front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on any error"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# A failing check ends in $$fatal, so the run returns a non-zero status
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_rp_analog.sv
// Directed testbench for the analog top, run from the project root through the Makefile
`default_nettype none

`include "rp_analog_macros.svh"

module tb_rp_analog;

  import rp_analog_pkg::*;

  localparam int DAC_MAX = (1 << (`RP_DAC_W-1)) - 1;  // +8191
  localparam int DAC_MIN = -(1 << (`RP_DAC_W-1));     // -8192

  logic                 adc_clk, rst_i, pll_locked_i;
  adc_pair_t            adc_raw_i;
  logic                 adc_raw_dv_i;
  dac_pair_t            asg_i, pid_i;
  loop_cfg_t            loop_i;
  exp_side_t            exp_p_ctrl_i, exp_n_ctrl_i;
  logic [`RP_EXP_W-1:0] exp_p_in_i;
  logic                 trig_asg_i, trig_scope_i, trig_sel_i;
  logic                 core_rst_o, adc_dv_o, trig_ext_o;
  adc_pair_t            adc_o;
  code_pair_t           dac_o;
  exp_side_t            exp_p_o, exp_n_o;
  logic [31:0]          seed = 32'he365;  // Xorshift state

  rp_analog_top dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // Period 40
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  // 13 bit signed, two of them never leave DAC range
  function automatic int rand_small();
    logic [31:0] r;
    r = next_rand();
    return int'($signed(r[12:0]));
  endfunction

  function automatic int clamp_dac(input int s);
    if (s > DAC_MAX) return DAC_MAX;
    if (s < DAC_MIN) return DAC_MIN;
    return s;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail %s: got %h, expected %h", name, got, expected);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Errors found");
    $fatal(1, "wait timed out");
  endtask

  // Counts falling edges until core reset reaches the level
  task automatic wait_core_rst(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (core_rst_o !== level) begin
      if (cycles == limit) begin
        report_timeout("core reset level");
      end else begin
        @(negedge adc_clk);
        cycles++;
      end
    end
  endtask

  task automatic drive_sum(input int a_asg, input int a_pid, input int b_asg, input int b_pid);
    asg_i.a = 14'(a_asg);
    pid_i.a = 14'(a_pid);
    asg_i.b = 14'(b_asg);
    pid_i.b = 14'(b_pid);
  endtask

  // Negative slope, +max at code 0 and -max at the top
  task automatic check_dac(input int sum_a, input int sum_b);
    check_equal("dac_o.a", 32'(dac_o.a), DAC_MAX - clamp_dac(sum_a));
    check_equal("dac_o.b", 32'(dac_o.b), DAC_MAX - clamp_dac(sum_b));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_lock_reset();
    int cycles;
    adc_raw_i    = next_rand();                      // Busy inputs while held in reset
    adc_raw_dv_i = 1'b1;
    drive_sum(1000, 2000, -1000, -2000);
    repeat (8) @(negedge adc_clk);
    check_equal("core_rst_o", 32'(core_rst_o), 1);  // No lock yet
    check_equal("adc_o", 32'(adc_o), 0);            // Stages held cleared
    check_equal("adc_dv_o", 32'(adc_dv_o), 0);
    check_equal("dac_o.a", 32'(dac_o.a), 32'h1fff);  // Zero code
    check_equal("dac_o.b", 32'(dac_o.b), 32'h1fff);
    pll_locked_i = 1'b1;
    wait_core_rst(1'b0, 200, cycles);
    check_equal("core_rst_o release delay", cycles, `RP_RST_CYCLES + 3);
    pll_locked_i = 1'b0;                             // Lock lost
    wait_core_rst(1'b1, 10, cycles);
    check_equal("core_rst_o assert delay", cycles, 3);
    pll_locked_i = 1'b1;
    wait_core_rst(1'b0, 200, cycles);
  endtask

  task automatic test_dac_sum();
    int a1, a2, b1, b2;
    loop_i = '0;
    repeat (20) begin
      a1 = rand_small();
      a2 = rand_small();
      b1 = rand_small();
      b2 = rand_small();
      drive_sum(a1, a2, b1, b2);
      @(negedge adc_clk);
      check_dac(a1 + a2, b1 + b2);
    end
  endtask

  task automatic test_saturation();
    drive_sum(DAC_MAX, 1, DAC_MIN, -1);      // Just past both limits
    @(negedge adc_clk);
    check_equal("dac_o.a", 32'(dac_o.a), 32'h0000);
    check_equal("dac_o.b", 32'(dac_o.b), 32'h3fff);
    drive_sum(-8000, -900, 6000, 4000);
    @(negedge adc_clk);
    check_equal("dac_o.a", 32'(dac_o.a), 32'h3fff);
    check_equal("dac_o.b", 32'(dac_o.b), 32'h0000);
    drive_sum(DAC_MAX, DAC_MAX, DAC_MIN, DAC_MIN);
    @(negedge adc_clk);
    check_dac(2 * DAC_MAX, 2 * DAC_MIN);
  endtask

  task automatic test_adc_path();
    logic [31:0] r;
    logic [15:0] exp_a, exp_b;
    int          a1, a2, b1, b2;
    loop_i = '0;
    repeat (10) begin
      r = next_rand();
      adc_raw_i = r;
      r = next_rand();
      adc_raw_dv_i = r[0];
      @(negedge adc_clk);
      check_equal("adc_o", 32'(adc_o), 32'(adc_raw_i));
      check_equal("adc_dv_o", 32'(adc_dv_o), 32'(adc_raw_dv_i));
    end
    loop_i.dac_to_adc = 1'b1;
    adc_raw_dv_i = 1'b0;                     // Loop forces valid anyway
    repeat (10) begin
      a1 = rand_small() * 2;                 // Wider range, some saturate
      a2 = rand_small();
      b1 = rand_small();
      b2 = rand_small() * 2;
      drive_sum(a1, a2, b1, b2);
      exp_a = 16'(clamp_dac(a1 + a2) * (1 << `RP_LOOP_SHIFT));
      exp_b = 16'(clamp_dac(b1 + b2) * (1 << `RP_LOOP_SHIFT));
      @(negedge adc_clk);
      check_equal("adc_o.a", 32'(adc_o.a), 32'(exp_a));
      check_equal("adc_o.b", 32'(adc_o.b), 32'(exp_b));
      check_equal("adc_dv_o", 32'(adc_dv_o), 1);
    end
  endtask

  task automatic test_dac_loopback();
    logic [31:0] r;
    loop_i = 2'b10;                          // adc_to_dac only
    repeat (10) begin
      r = next_rand();
      adc_raw_i = r;
      drive_sum(rand_small(), rand_small(), rand_small(), rand_small());  // Ignored
      @(negedge adc_clk);
      check_equal("dac_o.a", 32'(dac_o.a), 32'(r[31:18]));  // Top 14 of each word
      check_equal("dac_o.b", 32'(dac_o.b), 32'(r[15:2]));
    end
    loop_i = '0;
  endtask

  task automatic test_exp_override();
    logic [31:0] r;
    logic        trig;
    repeat (16) begin
      r = next_rand();
      exp_p_ctrl_i = r[15:0];
      exp_n_ctrl_i = r[31:16];
      r = next_rand();
      exp_p_in_i   = r[`RP_EXP_W-1:0];
      trig_asg_i   = r[8];
      trig_scope_i = r[9];
      trig_sel_i   = r[10];
      trig = trig_sel_i ? trig_asg_i : trig_scope_i;
      @(posedge adc_clk);                    // Combinational, settled by now
      check_equal("exp_p_o", 32'(exp_p_o), 32'(exp_p_ctrl_i));
      check_equal("exp_n_o.dat[0]", 32'(exp_n_o.dat[0]), 32'(trig));
      check_equal("exp_n_o.dir[0]", 32'(exp_n_o.dir[0]), 1);
      check_equal("exp_n_o.dat upper", 32'(exp_n_o.dat[`RP_EXP_W-1:1]),
                  32'(exp_n_ctrl_i.dat[`RP_EXP_W-1:1]));
      check_equal("exp_n_o.dir upper", 32'(exp_n_o.dir[`RP_EXP_W-1:1]),
                  32'(exp_n_ctrl_i.dir[`RP_EXP_W-1:1]));
      check_equal("trig_ext_o", 32'(trig_ext_o), 32'(exp_p_in_i[0]));
      @(negedge adc_clk);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    rst_i        = 1'b1;
    pll_locked_i = 1'b0;
    adc_raw_i    = '0;
    adc_raw_dv_i = 1'b0;
    asg_i        = '0;
    pid_i        = '0;
    loop_i       = '0;
    exp_p_ctrl_i = '0;
    exp_n_ctrl_i = '0;
    exp_p_in_i   = '0;
    trig_asg_i   = 1'b0;
    trig_scope_i = 1'b0;
    trig_sel_i   = 1'b0;
    repeat (16) @(negedge adc_clk);
    rst_i = 1'b0;
    test_lock_reset();
    test_dac_sum();
    test_saturation();
    test_adc_path();
    test_dac_loopback();
    test_exp_override();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rp_analog_top.sv
// Board top for the analog path, ties reset sequencing, ADC and DAC stages and the expansion mux
`default_nettype none

`include "rp_analog_macros.svh"

module rp_analog_top (
  input  logic                      adc_clk,
  input  logic                      rst_i,
  input  logic                      pll_locked_i,
  input  rp_analog_pkg::adc_pair_t  adc_raw_i,     // Converter samples
  input  logic                      adc_raw_dv_i,
  input  rp_analog_pkg::dac_pair_t  asg_i,         // Generator words
  input  rp_analog_pkg::dac_pair_t  pid_i,         // Controller words
  input  rp_analog_pkg::loop_cfg_t  loop_i,
  input  rp_analog_pkg::exp_side_t  exp_p_ctrl_i,
  input  rp_analog_pkg::exp_side_t  exp_n_ctrl_i,
  input  logic [`RP_EXP_W-1:0]      exp_p_in_i,
  input  logic                      trig_asg_i,
  input  logic                      trig_scope_i,
  input  logic                      trig_sel_i,
  output logic                      core_rst_o,    // Also resets the stages below
  output rp_analog_pkg::adc_pair_t  adc_o,
  output logic                      adc_dv_o,
  output rp_analog_pkg::code_pair_t dac_o,
  output rp_analog_pkg::exp_side_t  exp_p_o,
  output rp_analog_pkg::exp_side_t  exp_n_o,
  output logic                      trig_ext_o
);

  import rp_analog_pkg::*;

  dac_pair_t sat_pair;  // Clamped ASG + PID

  lock_reset_gen i_lock_rst (
    .adc_clk      (adc_clk     ),
    .rst_i        (rst_i       ),
    .pll_locked_i (pll_locked_i),
    .core_rst_o   (core_rst_o  )
  );

  ////////////////////////////////////////
  // DAC sum, one per channel
  ////////////////////////////////////////

  dac_sum_sat i_sum_a (.asg_i (asg_i.a), .pid_i (pid_i.a), .sat_o (sat_pair.a));
  dac_sum_sat i_sum_b (.asg_i (asg_i.b), .pid_i (pid_i.b), .sat_o (sat_pair.b));

  adc_input_stage i_adc_in (
    .adc_clk      (adc_clk     ),
    .rst_i        (core_rst_o  ),
    .adc_raw_i    (adc_raw_i   ),
    .adc_raw_dv_i (adc_raw_dv_i),
    .sat_i        (sat_pair    ),  // Digital loop source
    .loop_i       (loop_i      ),
    .adc_o        (adc_o       ),
    .adc_dv_o     (adc_dv_o    )
  );

  dac_output_stage i_dac_out (
    .adc_clk   (adc_clk   ),
    .rst_i     (core_rst_o),
    .sat_i     (sat_pair  ),
    .adc_raw_i (adc_raw_i ),  // Loopback source
    .loop_i    (loop_i    ),
    .dac_o     (dac_o     )
  );

  exp_io_mux i_exp_mux (
    .exp_p_ctrl_i (exp_p_ctrl_i),
    .exp_n_ctrl_i (exp_n_ctrl_i),
    .exp_p_in_i   (exp_p_in_i  ),
    .trig_asg_i   (trig_asg_i  ),
    .trig_scope_i (trig_scope_i),
    .trig_sel_i   (trig_sel_i  ),
    .exp_p_o      (exp_p_o     ),
    .exp_n_o      (exp_n_o     ),
    .trig_ext_o   (trig_ext_o  )
  );

endmodule

`default_nettype wire

// File: hdl/exp_io_mux.sv
// Expansion connector mux, puts the selected trigger on pin n[0] and reads the external trigger
`default_nettype none

`include "rp_analog_macros.svh"

module exp_io_mux (
  input  rp_analog_pkg::exp_side_t exp_p_ctrl_i,  // Housekeeping, p side
  input  rp_analog_pkg::exp_side_t exp_n_ctrl_i,  // Housekeeping, n side
  input  logic [`RP_EXP_W-1:0]     exp_p_in_i,    // P pins as read
  input  logic                     trig_asg_i,
  input  logic                     trig_scope_i,
  input  logic                     trig_sel_i,    // 1 picks ASG trigger
  output rp_analog_pkg::exp_side_t exp_p_o,
  output rp_analog_pkg::exp_side_t exp_n_o,
  output logic                     trig_ext_o
);

  localparam int EXP_W = `RP_EXP_W;

  // Pins taken over from housekeeping on n side
  localparam logic [EXP_W-1:0] N_ALT = EXP_W'(1);

  logic             trig_out;   // Trigger sent off board
  logic [EXP_W-1:0] n_alt_dat;  // Alternate data per pin

  ////////////////////////////////////////
  // Trigger out
  ////////////////////////////////////////

  assign trig_out  = trig_sel_i ? trig_asg_i : trig_scope_i;
  assign n_alt_dat = {{(EXP_W-1){1'b0}}, trig_out};

  // Per pin override, rest follows housekeeping
  always_comb begin
    exp_n_o.dat = (n_alt_dat & N_ALT) | (exp_n_ctrl_i.dat & ~N_ALT);
    exp_n_o.dir = N_ALT | (exp_n_ctrl_i.dir & ~N_ALT);  // Alternate pins always drive
  end

  // P side has no alternate function here
  assign exp_p_o = exp_p_ctrl_i;

  ////////////////////////////////////////
  // Trigger in
  ////////////////////////////////////////

  assign trig_ext_o = exp_p_in_i[0];  // External trigger on p[0]

endmodule

`default_nettype wire

// File: hdl/dac_output_stage.sv
// DAC output register, codes both channels for the converter or loops the raw ADC word back
`default_nettype none

`include "rp_analog_macros.svh"

module dac_output_stage (
  input  logic                      adc_clk,
  input  logic                      rst_i,
  input  rp_analog_pkg::dac_pair_t  sat_i,      // Saturated two's complement
  input  rp_analog_pkg::adc_pair_t  adc_raw_i,  // Raw converter samples
  input  rp_analog_pkg::loop_cfg_t  loop_i,
  output rp_analog_pkg::code_pair_t dac_o       // To DAC pins
);

  import rp_analog_pkg::*;

  localparam int DAC_W = `RP_DAC_W;

  // Code for a zero word, hex 1FFF
  localparam dac_code_t ZERO_CODE = {1'b0, {(DAC_W-1){1'b1}}};

  code_pair_t code_nxt;

  // Sign kept, magnitude bits flipped for negative slope
  function automatic dac_code_t to_code(dac_word_t w);
    return {w[DAC_W-1], ~w[DAC_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // Code select and register
  ////////////////////////////////////////

  always_comb begin
    if (loop_i.adc_to_dac) begin
      code_nxt.a = adc_raw_i.a.split.msb;  // No conversion on loopback
      code_nxt.b = adc_raw_i.b.split.msb;
    end else begin
      code_nxt.a = to_code(sat_i.a);
      code_nxt.b = to_code(sat_i.b);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_o.a <= ZERO_CODE;  // Converter idles at midscale
      dac_o.b <= ZERO_CODE;
    end else begin
      dac_o <= code_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/dac_sum_sat.sv
// Adds generator and controller words of one channel and clamps the sum to the DAC range
`default_nettype none

`include "rp_analog_macros.svh"

module dac_sum_sat (
  input  rp_analog_pkg::dac_word_t asg_i,  // Generator word
  input  rp_analog_pkg::dac_word_t pid_i,  // Controller word
  output rp_analog_pkg::dac_word_t sat_o   // Clamped sum
);

  import rp_analog_pkg::*;

  localparam int SUM_W = `RP_SUM_W;
  localparam int DAC_W = `RP_DAC_W;

  // Clamp limits
  localparam dac_word_t SAT_MAX = {1'b0, {(DAC_W-1){1'b1}}};  // +8191
  localparam dac_word_t SAT_MIN = {1'b1, {(DAC_W-1){1'b0}}};  // -8192

  logic signed [SUM_W-1:0] sum;
  logic                    ovf;   // Sum outside DAC range

  ////////////////////////////////////////
  // Sum and clamp
  ////////////////////////////////////////

  assign sum = SUM_W'(asg_i) + SUM_W'(pid_i);  // Sign extended add

  // Guard bit and DAC sign disagree
  assign ovf = sum[SUM_W-1] ^ sum[SUM_W-2];

  always_comb begin
    if (ovf) begin
      sat_o = sum[SUM_W-1] ? SAT_MIN : SAT_MAX;  // Direction from true sign
    end else begin
      sat_o = sum[DAC_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hdl/adc_input_stage.sv
// ADC input register for both channels, picks the raw converter data or the digital DAC loop
`default_nettype none

`include "rp_analog_macros.svh"

module adc_input_stage (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  rp_analog_pkg::adc_pair_t adc_raw_i,     // From converter
  input  logic                     adc_raw_dv_i,
  input  rp_analog_pkg::dac_pair_t sat_i,         // Saturated DAC words
  input  rp_analog_pkg::loop_cfg_t loop_i,
  output rp_analog_pkg::adc_pair_t adc_o,         // To scope and PID
  output logic                     adc_dv_o
);

  import rp_analog_pkg::*;

  adc_pair_t loop_pair;  // DAC words scaled to ADC range

  // 14 bit word lands in top of 16 bit sample
  always_comb begin
    loop_pair.a.sample = adc_sample_t'(sat_i.a) <<< `RP_LOOP_SHIFT;
    loop_pair.b.sample = adc_sample_t'(sat_i.b) <<< `RP_LOOP_SHIFT;
  end

  ////////////////////////////////////////
  // Sample register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_o    <= '0;
      adc_dv_o <= 1'b0;
    end else if (loop_i.dac_to_adc) begin
      adc_o    <= loop_pair;
      adc_dv_o <= 1'b1;             // Loop data valid every cycle
    end else begin
      adc_o    <= adc_raw_i;
      adc_dv_o <= adc_raw_dv_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lock_reset_gen.sv
// Core reset generator, holds reset until the sampling clock is locked and then for a fixed count
`default_nettype none

`include "rp_analog_macros.svh"

module lock_reset_gen (
  input  logic adc_clk,
  input  logic rst_i,
  input  logic pll_locked_i,  // Lock level, asynchronous
  output logic core_rst_o     // Reset for the rest of the core
);

  localparam int RST_CYCLES = `RP_RST_CYCLES;
  localparam int CNT_W      = $clog2(RST_CYCLES);
  // Load one short, the output flop adds the last cycle
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(RST_CYCLES - 1);

  logic             lock_s1;    // First sync stage
  logic             lock_s2;    // Synchronized lock
  logic             lock_d;     // Delayed copy
  logic             lock_rise;
  logic [CNT_W-1:0] rst_cnt;    // Cycles left after lock

  ////////////////////////////////////////
  // Lock synchronizer
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      lock_s1 <= 1'b0;
      lock_s2 <= 1'b0;
      lock_d  <= 1'b0;
    end else begin
      lock_s1 <= pll_locked_i;
      lock_s2 <= lock_s1;
      lock_d  <= lock_s2;
    end
  end

  assign lock_rise = lock_s2 & ~lock_d;  // Seen on third edge

  ////////////////////////////////////////
  // Post-lock counter
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i || !lock_s2) begin
      rst_cnt <= '0;                     // Lost lock restarts sequence
    end else if (lock_rise) begin
      rst_cnt <= CNT_LOAD;
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - CNT_W'(1);
    end
  end

  // Registered so the core sees a clean level
  always_ff @(posedge adc_clk) begin
    core_rst_o <= rst_i | ~lock_s2 | lock_rise | (rst_cnt != '0);
  end

endmodule

`default_nettype wire

// File: hdl/rp_analog_pkg.sv
// Sample, channel pair and configuration types shared by every analog front-end module
`default_nettype none

`include "rp_analog_macros.svh"

package rp_analog_pkg;

  typedef logic signed [`RP_ADC_W-1:0] adc_sample_t;  // One ADC sample
  typedef logic signed [`RP_DAC_W-1:0] dac_word_t;    // One DAC word before coding
  typedef logic        [`RP_DAC_W-1:0] dac_code_t;    // Offset code, negative slope

  // Upper bits feed DAC loopback and PID
  typedef struct packed {
    logic [`RP_DAC_W-1:0]           msb;
    logic [`RP_ADC_W-`RP_DAC_W-1:0] lsb;  // Dropped by the 14 bit users
  } adc_split_t;

  // Same ADC word, full sample or split view
  typedef union packed {
    adc_sample_t sample;  // Scope and PID view
    adc_split_t  split;
  } adc_word_u;

  typedef struct packed { adc_word_u a; adc_word_u b; } adc_pair_t;
  typedef struct packed { dac_word_t a; dac_word_t b; } dac_pair_t;
  typedef struct packed { dac_code_t a; dac_code_t b; } code_pair_t;

  // Loop register layout, bit 1 then bit 0
  typedef struct packed {
    logic adc_to_dac;  // Raw ADC straight to DAC
    logic dac_to_adc;  // DAC words back as ADC samples
  } loop_cfg_t;

  // One connector side
  typedef struct packed {
    logic [`RP_EXP_W-1:0] dat;  // Output data
    logic [`RP_EXP_W-1:0] dir;  // 1 drives the pin
  } exp_side_t;

endpackage

`default_nettype wire

// File: hdl/rp_analog_macros.svh
// Widths and counts for the analog front end, included by the package and by RTL needing them
`ifndef RP_ANALOG_MACROS_SVH
`define RP_ANALOG_MACROS_SVH

////////////////////////////////////////
// Converter widths
////////////////////////////////////////

`define RP_ADC_W 16        // ADC sample, two's complement
`define RP_DAC_W 14        // DAC word, two's complement
`define RP_SUM_W 15        // ASG + PID sum, one guard bit

// Digital loop scaling, DAC word up to ADC range
`define RP_LOOP_SHIFT 2

////////////////////////////////////////
// Board level counts
////////////////////////////////////////

`define RP_EXP_W 8         // Pins per expansion side

// Core reset held this long after lock
`define RP_RST_CYCLES 64

`endif
